// ==== glb_tile.f ====
glb_mem_pkg.sv
glb_reg_pkg.sv
glb_bank.sv
glb_bank_arb.sv
glb_st_dma.sv
glb_ld_dma.sv
glb_tile_cfg.sv
glb_tile.sv
tb_glb_tile.sv

// ==== Makefile ====
# Verilator build and run of the glb_tile testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_glb_tile
FILELIST  := glb_tile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_glb_tile.sv ====
// Testbench with clock, reset, APB tasks, store and load streams, reference memory and timeout
`timescale 1ns/1ps

module tb_glb_tile;
    import glb_mem_pkg::*;
    import glb_reg_pkg::*;

    // Sum of all stream lengths used below
    localparam int TOTAL_WORDS = 32 + 32 + 16 + 16 + 10 + 24 + 16 + 24;
    localparam int MAX_CYCLES  = 4 * TOTAL_WORDS + 500;

    logic                      clk;
    logic                      arst_n;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
    logic                      st_data_valid;
    logic [DATA_WIDTH-1:0]     st_data;
    logic                      st_data_ready;
    logic                      ld_data_valid;
    logic [DATA_WIDTH-1:0]     ld_data;
    logic                      ld_data_ready;

    logic [DATA_WIDTH-1:0]     ref_mem [BANK_DEPTH];
    logic [DATA_WIDTH-1:0]     exp_q [$];
    logic [15:0]               lfsr;
    logic                      random_ready;
    int                        errors;
    int                        cycles;

    glb_tile DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the DMA streams did not finish", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic int st_reg(input int slot, input int ofs);
        return REG_ST_HDR_BASE + slot * REG_HDR_STRIDE + ofs;
    endfunction

    function automatic int ld_reg(input int slot, input int ofs);
        return REG_LD_HDR_BASE + slot * REG_HDR_STRIDE + ofs;
    endfunction

    task automatic log_failure(input string msg);
        errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    // Setup then access phase with the response sampled mid cycle
    task automatic apb_xfer(input logic wr, input int addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = APB_ADDR_WIDTH'(addr);
        pwdata  = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input int addr, input logic [31:0] wdata);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, wdata, rd, err);
        assert (!err) else log_failure($sformatf("write to 0x%0h got pslverr", addr));
    endtask

    task automatic expect_reg(input int addr, input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b0, addr, '0, rd, err);
        assert (!err && rd == exp)
            else log_failure($sformatf("reg 0x%0h read 0x%0h, expected 0x%0h", addr, rd, exp));
    endtask

    // Poll until the DMA has cleared the valid bit
    task automatic wait_clear(input int addr);
        logic [31:0] rd;
        logic        err;
        do begin
            apb_xfer(1'b0, addr, '0, rd, err);
        end while (rd[0]);
    endtask

    task automatic program_store(input int slot, input int start, input int n);
        apb_write(st_reg(slot, OFS_START_ADDR), start);
        apb_write(st_reg(slot, OFS_NUM_WORDS), n);
        apb_write(st_reg(slot, OFS_VALIDATE), 1);
    endtask

    // Word k of a store header lands at start + k
    task automatic drive_stream(input int start, input int n);
        logic xfer;
        for (int k = 0; k < n; k++) begin
            st_data       = rand_bits(DATA_WIDTH);
            st_data_valid = 1'b1;
            ref_mem[(start + k) % BANK_DEPTH] = st_data;
            xfer = 1'b0;
            while (!xfer) begin
                @(negedge clk);
                xfer = st_data_ready;
                @(posedge clk);
                #2;
            end
        end
        st_data_valid = 1'b0;
    endtask

    task automatic program_load(input int slot, input int start, input int n, input int stride);
        for (int i = 0; i < n; i++)
            exp_q.push_back(ref_mem[(start + i * stride) % BANK_DEPTH]);
        apb_write(ld_reg(slot, OFS_START_ADDR), start);
        apb_write(ld_reg(slot, OFS_RANGE), n);
        apb_write(ld_reg(slot, OFS_STRIDE), stride);
        apb_write(ld_reg(slot, OFS_VALIDATE), 1);
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0)
            @(posedge clk);
        #2;
    endtask

    always @(posedge clk) begin
        #2;
        ld_data_ready = random_ready ? (rand_bits(1) != 16'd0) : 1'b1;
    end

    always @(negedge clk) begin
        if (arst_n && ld_data_valid && ld_data_ready) begin
            assert (exp_q.size() > 0 && ld_data == exp_q[0])
                else log_failure($sformatf("load word 0x%0h, expected 0x%0h (%0d pending)",
                                           ld_data, exp_q[0], exp_q.size()));
            if (exp_q.size() > 0)
                void'(exp_q.pop_front());
        end
    end

    assert property (@(posedge clk) !arst_n |-> !st_data_ready && !ld_data_valid && !pslverr)
        else log_failure("stream or error outputs active during reset");

    // The APB slave has no wait states
    assert property (@(posedge clk) disable iff (!arst_n) psel && penable |-> pready)
        else log_failure("pready low in APB access phase");

    // A stalled load word must be held
    assert property (@(posedge clk) disable iff (!arst_n)
        ld_data_valid && !ld_data_ready |=> ld_data_valid && $stable(ld_data))
        else log_failure("load word dropped or changed while stalled");

    initial begin
        logic [31:0] rd;
        logic        err;
        errors        = 0;
        cycles        = 0;
        lfsr          = 16'd34428;
        random_ready  = 1'b0;
        arst_n        = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        st_data_valid = 1'b0;
        st_data       = '0;
        ld_data_ready = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;

        // Every register reads 0 and only the fourth word of store slot 0 is unmapped
        for (int a = 0; a < (1 << APB_ADDR_WIDTH); a += 4) begin
            apb_xfer(1'b0, a, '0, rd, err);
            assert (rd == 0 && err == (a == st_reg(0, OFS_STRIDE)))
                else log_failure($sformatf("reset read 0x%0h gave 0x%0h err %0b", a, rd, err));
        end
        apb_write(REG_TILE_CTRL, (1 << CTRL_ST_EN_BIT) | (1 << CTRL_LD_EN_BIT));

        // Store and load back across the bank wrap
        program_store(0, 'h3F0, 32);
        drive_stream('h3F0, 32);
        wait_clear(st_reg(0, OFS_VALIDATE));
        program_load(0, 'h3F0, 32, 1);
        wait_drained();
        expect_reg(ld_reg(0, OFS_VALIDATE), 0);

        // Second slot in each direction
        program_store(1, 'h100, 16);
        drive_stream('h100, 16);
        wait_clear(st_reg(1, OFS_VALIDATE));
        program_load(1, 'h100, 16, 1);
        wait_drained();
        expect_reg(ld_reg(1, OFS_VALIDATE), 0);

        // Stride 3 load that wraps past the top of the bank
        program_load(0, 'h3F0, 10, 3);
        wait_drained();
        expect_reg(ld_reg(0, OFS_VALIDATE), 0);

        // Store and stalled load share the bank
        random_ready = 1'b1;
        program_store(0, 'h200, 24);
        program_load(1, 'h100, 16, 1);
        fork
            drive_stream('h200, 24);
            wait_drained();
        join
        wait_clear(st_reg(0, OFS_VALIDATE));
        expect_reg(ld_reg(1, OFS_VALIDATE), 0);
        random_ready = 1'b0;
        program_load(0, 'h200, 24, 1);
        wait_drained();
        expect_reg(ld_reg(0, OFS_VALIDATE), 0);

        $display("Run finished after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== glb_tile.sv ====
// Module glb_tile: global buffer tile top with register file, DMAs, arbiter and bank
`timescale 1ns/1ps

module glb_tile (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [glb_reg_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic [glb_reg_pkg::APB_DATA_WIDTH-1:0] pwdata,
    input  logic                                  st_data_valid,
    input  logic [glb_mem_pkg::DATA_WIDTH-1:0]     st_data,
    input  logic                                  ld_data_ready,
    output logic [glb_reg_pkg::APB_DATA_WIDTH-1:0] prdata,
    output logic                                  pready,
    output logic                                  pslverr,
    output logic                                  st_data_ready,
    output logic                                  ld_data_valid,
    output logic [glb_mem_pkg::DATA_WIDTH-1:0]     ld_data
);
    import glb_mem_pkg::*;

    // Register file to DMAs
    logic                       st_dma_en;
    logic                       ld_dma_en;
    dma_st_header_t             st_dma_header [QUEUE_DEPTH];
    dma_ld_header_t             ld_dma_header [QUEUE_DEPTH];
    logic                       st_invalidate_pulse [QUEUE_DEPTH];
    logic                       ld_invalidate_pulse [QUEUE_DEPTH];

    // DMAs to arbiter
    logic                       st_req;
    logic                       st_gnt;
    logic [BANK_ADDR_WIDTH-1:0] st_addr;
    logic [DATA_WIDTH-1:0]      st_wdata;
    logic                       ld_req;
    logic                       ld_gnt;
    logic [BANK_ADDR_WIDTH-1:0] ld_addr;
    logic                       ld_rdata_valid;
    logic [DATA_WIDTH-1:0]      ld_rdata;

    // Arbiter to bank
    logic                       bank_en;
    logic                       bank_we;
    logic [BANK_ADDR_WIDTH-1:0] bank_addr;
    logic [DATA_WIDTH-1:0]      bank_wdata;
    logic [DATA_WIDTH-1:0]      bank_rdata;

    glb_tile_cfg glb_tile_cfg (.*);

    glb_st_dma glb_st_dma (.*);

    glb_ld_dma glb_ld_dma (.*);

    glb_bank_arb glb_bank_arb (.*);

    glb_bank glb_bank (.*);

endmodule

// ==== glb_tile_cfg.sv ====
// Module glb_tile_cfg: APB register file holding tile control and DMA headers
`timescale 1ns/1ps

module glb_tile_cfg (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [glb_reg_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic [glb_reg_pkg::APB_DATA_WIDTH-1:0] pwdata,
    input  logic                                  st_invalidate_pulse [glb_mem_pkg::QUEUE_DEPTH],
    input  logic                                  ld_invalidate_pulse [glb_mem_pkg::QUEUE_DEPTH],
    output logic [glb_reg_pkg::APB_DATA_WIDTH-1:0] prdata,
    output logic                                  pready,
    output logic                                  pslverr,
    output logic                                  st_dma_en,
    output logic                                  ld_dma_en,
    output glb_mem_pkg::dma_st_header_t           st_dma_header [glb_mem_pkg::QUEUE_DEPTH],
    output glb_mem_pkg::dma_ld_header_t           ld_dma_header [glb_mem_pkg::QUEUE_DEPTH]
);
    import glb_mem_pkg::*;
    import glb_reg_pkg::*;

    logic wr_en;
    logic reg_hit;

    function automatic logic [APB_ADDR_WIDTH-1:0] hdr_addr(input int base, input int slot,
                                                            input int ofs);
        return APB_ADDR_WIDTH'(base + slot * REG_HDR_STRIDE + ofs);
    endfunction

    // No wait states
    assign pready  = 1'b1;
    assign wr_en   = psel && penable && pwrite;
    assign pslverr = psel && penable && !reg_hit;

    // Read mux, shows valid bits as cleared by the DMAs
    always_comb begin
        prdata  = '0;
        reg_hit = 1'b0;
        if (paddr == APB_ADDR_WIDTH'(REG_TILE_CTRL)) begin
            reg_hit                = 1'b1;
            prdata[CTRL_ST_EN_BIT] = st_dma_en;
            prdata[CTRL_LD_EN_BIT] = ld_dma_en;
        end
        for (int q = 0; q < QUEUE_DEPTH; q++) begin
            if (paddr == hdr_addr(REG_ST_HDR_BASE, q, OFS_VALIDATE)) begin
                reg_hit   = 1'b1;
                prdata[0] = st_dma_header[q].valid;
            end
            if (paddr == hdr_addr(REG_ST_HDR_BASE, q, OFS_START_ADDR)) begin
                reg_hit                         = 1'b1;
                prdata[BANK_ADDR_WIDTH-1:0]     = st_dma_header[q].start_addr;
            end
            if (paddr == hdr_addr(REG_ST_HDR_BASE, q, OFS_NUM_WORDS)) begin
                reg_hit                         = 1'b1;
                prdata[NUM_WORDS_WIDTH-1:0]     = st_dma_header[q].num_words;
            end
            if (paddr == hdr_addr(REG_LD_HDR_BASE, q, OFS_VALIDATE)) begin
                reg_hit   = 1'b1;
                prdata[0] = ld_dma_header[q].valid;
            end
            if (paddr == hdr_addr(REG_LD_HDR_BASE, q, OFS_START_ADDR)) begin
                reg_hit                         = 1'b1;
                prdata[BANK_ADDR_WIDTH-1:0]     = ld_dma_header[q].start_addr;
            end
            if (paddr == hdr_addr(REG_LD_HDR_BASE, q, OFS_RANGE)) begin
                reg_hit                         = 1'b1;
                prdata[NUM_WORDS_WIDTH-1:0]     = ld_dma_header[q].range;
            end
            if (paddr == hdr_addr(REG_LD_HDR_BASE, q, OFS_STRIDE)) begin
                reg_hit                         = 1'b1;
                prdata[STRIDE_WIDTH-1:0]        = ld_dma_header[q].stride;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            st_dma_en <= 1'b0;
            ld_dma_en <= 1'b0;
            for (int q = 0; q < QUEUE_DEPTH; q++) begin
                st_dma_header[q] <= '0;
                ld_dma_header[q] <= '0;
            end
        end else begin
            // Hardware clear comes first, a software write in the same cycle wins
            for (int q = 0; q < QUEUE_DEPTH; q++) begin
                if (st_invalidate_pulse[q])
                    st_dma_header[q].valid <= 1'b0;
                if (ld_invalidate_pulse[q])
                    ld_dma_header[q].valid <= 1'b0;
            end
            if (wr_en) begin
                if (paddr == APB_ADDR_WIDTH'(REG_TILE_CTRL)) begin
                    st_dma_en <= pwdata[CTRL_ST_EN_BIT];
                    ld_dma_en <= pwdata[CTRL_LD_EN_BIT];
                end
                for (int q = 0; q < QUEUE_DEPTH; q++) begin
                    if (paddr == hdr_addr(REG_ST_HDR_BASE, q, OFS_VALIDATE))
                        st_dma_header[q].valid <= pwdata[0];
                    if (paddr == hdr_addr(REG_ST_HDR_BASE, q, OFS_START_ADDR))
                        st_dma_header[q].start_addr <= pwdata[BANK_ADDR_WIDTH-1:0];
                    if (paddr == hdr_addr(REG_ST_HDR_BASE, q, OFS_NUM_WORDS))
                        st_dma_header[q].num_words <= pwdata[NUM_WORDS_WIDTH-1:0];
                    if (paddr == hdr_addr(REG_LD_HDR_BASE, q, OFS_VALIDATE))
                        ld_dma_header[q].valid <= pwdata[0];
                    if (paddr == hdr_addr(REG_LD_HDR_BASE, q, OFS_START_ADDR))
                        ld_dma_header[q].start_addr <= pwdata[BANK_ADDR_WIDTH-1:0];
                    if (paddr == hdr_addr(REG_LD_HDR_BASE, q, OFS_RANGE))
                        ld_dma_header[q].range <= pwdata[NUM_WORDS_WIDTH-1:0];
                    if (paddr == hdr_addr(REG_LD_HDR_BASE, q, OFS_STRIDE))
                        ld_dma_header[q].stride <= pwdata[STRIDE_WIDTH-1:0];
                end
            end
        end
    end

    // Each DMA clears a slot with a single-cycle pulse
    for (genvar q = 0; q < QUEUE_DEPTH; q++) begin : g_pulse_chk
        assert property (@(posedge clk) disable iff (!arst_n)
            (st_invalidate_pulse[q] |=> !st_invalidate_pulse[q]) and
            (ld_invalidate_pulse[q] |=> !ld_invalidate_pulse[q]))
            else $error("invalidate pulse on slot %0d longer than one cycle", q);
    end

endmodule

// ==== glb_ld_dma.sv ====
// Module glb_ld_dma: load DMA issuing strided bank reads into a two-entry output FIFO
`timescale 1ns/1ps

module glb_ld_dma (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic                                   ld_dma_en,
    input  glb_mem_pkg::dma_ld_header_t            ld_dma_header [glb_mem_pkg::QUEUE_DEPTH],
    input  logic                                   ld_gnt,
    input  logic                                   ld_rdata_valid,
    input  logic [glb_mem_pkg::DATA_WIDTH-1:0]      ld_rdata,
    input  logic                                   ld_data_ready,
    output logic                                   ld_req,
    output logic [glb_mem_pkg::BANK_ADDR_WIDTH-1:0] ld_addr,
    output logic                                   ld_data_valid,
    output logic [glb_mem_pkg::DATA_WIDTH-1:0]      ld_data,
    output logic                                   ld_invalidate_pulse [glb_mem_pkg::QUEUE_DEPTH]
);
    import glb_mem_pkg::*;

    logic [QUEUE_PTR_WIDTH-1:0] slot;
    logic [NUM_WORDS_WIDTH-1:0] rd_cnt;
    logic [BANK_ADDR_WIDTH-1:0] rd_ofs;
    // Reads in flight plus words held in the FIFO
    logic [LD_CNT_WIDTH-1:0]    credit_cnt;
    logic [DATA_WIDTH-1:0]      fifo_mem [LD_FIFO_DEPTH];
    logic [LD_PTR_WIDTH-1:0]    wr_ptr;
    logic [LD_PTR_WIDTH-1:0]    rd_ptr;
    logic [LD_CNT_WIDTH-1:0]    fifo_cnt;
    dma_ld_header_t             hdr;
    logic                       active;
    logic                       done;
    logic                       issue;
    logic                       pop;

    assign hdr    = ld_dma_header[slot];
    assign active = hdr.valid && ld_dma_en;
    assign done   = active && (rd_cnt == hdr.range);

    assign ld_req  = active && (rd_cnt < hdr.range) &&
                     (credit_cnt < LD_CNT_WIDTH'(LD_FIFO_DEPTH));
    // Offset wraps at the bank depth
    assign ld_addr = hdr.start_addr + rd_ofs;
    assign issue   = ld_req && ld_gnt;

    assign ld_data_valid = (fifo_cnt != '0);
    assign ld_data       = fifo_mem[rd_ptr];
    assign pop           = ld_data_valid && ld_data_ready;

    always_comb begin
        for (int q = 0; q < QUEUE_DEPTH; q++) begin
            ld_invalidate_pulse[q] = done && (slot == QUEUE_PTR_WIDTH'(q));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot       <= '0;
            rd_cnt     <= '0;
            rd_ofs     <= '0;
            credit_cnt <= '0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_cnt   <= '0;
        end else begin
            if (done) begin
                slot   <= slot + 1'b1;
                rd_cnt <= '0;
                rd_ofs <= '0;
            end else if (issue) begin
                rd_cnt <= rd_cnt + 1'b1;
                rd_ofs <= rd_ofs + BANK_ADDR_WIDTH'(hdr.stride);
            end
            credit_cnt <= credit_cnt + LD_CNT_WIDTH'(issue) - LD_CNT_WIDTH'(pop);
            fifo_cnt   <= fifo_cnt + LD_CNT_WIDTH'(ld_rdata_valid) - LD_CNT_WIDTH'(pop);
            if (ld_rdata_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_rdata_valid)
            fifo_mem[wr_ptr] <= ld_rdata;
    end

    // Credit limit leaves room for every word the arbiter returns
    assert property (@(posedge clk) disable iff (!arst_n)
        ld_rdata_valid |-> fifo_cnt < LD_CNT_WIDTH'(LD_FIFO_DEPTH))
        else $error("load FIFO overflow");

endmodule

// ==== glb_st_dma.sv ====
// Module glb_st_dma: store DMA writing the incoming word stream into the bank per header
`timescale 1ns/1ps

module glb_st_dma (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic                                   st_dma_en,
    input  glb_mem_pkg::dma_st_header_t            st_dma_header [glb_mem_pkg::QUEUE_DEPTH],
    input  logic                                   st_data_valid,
    input  logic [glb_mem_pkg::DATA_WIDTH-1:0]      st_data,
    input  logic                                   st_gnt,
    output logic                                   st_data_ready,
    output logic                                   st_req,
    output logic [glb_mem_pkg::BANK_ADDR_WIDTH-1:0] st_addr,
    output logic [glb_mem_pkg::DATA_WIDTH-1:0]      st_wdata,
    output logic                                   st_invalidate_pulse [glb_mem_pkg::QUEUE_DEPTH]
);
    import glb_mem_pkg::*;

    logic [QUEUE_PTR_WIDTH-1:0] slot;
    logic [NUM_WORDS_WIDTH-1:0] wr_cnt;
    logic                       buf_full;
    logic [DATA_WIDTH-1:0]      buf_data;
    dma_st_header_t             hdr;
    logic                       active;
    logic                       done;

    assign hdr    = st_dma_header[slot];
    assign active = hdr.valid && st_dma_en;
    // Buffer is always empty once all words are written, zero-length headers finish at once
    assign done   = active && (wr_cnt == hdr.num_words);

    // Accept only as many words as the header asks for
    assign st_data_ready = active && !buf_full && (wr_cnt < hdr.num_words);

    assign st_req   = buf_full;
    assign st_addr  = hdr.start_addr + wr_cnt[BANK_ADDR_WIDTH-1:0];
    assign st_wdata = buf_data;

    always_comb begin
        for (int q = 0; q < QUEUE_DEPTH; q++) begin
            st_invalidate_pulse[q] = done && (slot == QUEUE_PTR_WIDTH'(q));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot     <= '0;
            wr_cnt   <= '0;
            buf_full <= 1'b0;
        end else begin
            if (done) begin
                slot   <= slot + 1'b1;
                wr_cnt <= '0;
            end else if (st_gnt) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (st_data_valid && st_data_ready)
                buf_full <= 1'b1;
            else if (st_gnt)
                buf_full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (st_data_valid && st_data_ready)
            buf_data <= st_data;
    end

    // Arbiter may delay the grant, the request must wait unchanged
    assert property (@(posedge clk) disable iff (!arst_n)
        st_req && !st_gnt |=> st_req && $stable(st_addr) && $stable(st_wdata))
        else $error("store request dropped or changed before grant");

endmodule

// ==== glb_bank_arb.sv ====
// Round-robin arbiter sharing the single bank port between the store and load DMAs
`timescale 1ns/1ps

module glb_bank_arb (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic                                   st_req,
    input  logic [glb_mem_pkg::BANK_ADDR_WIDTH-1:0] st_addr,
    input  logic [glb_mem_pkg::DATA_WIDTH-1:0]      st_wdata,
    input  logic                                   ld_req,
    input  logic [glb_mem_pkg::BANK_ADDR_WIDTH-1:0] ld_addr,
    input  logic [glb_mem_pkg::DATA_WIDTH-1:0]      bank_rdata,
    output logic                                   st_gnt,
    output logic                                   ld_gnt,
    output logic                                   bank_en,
    output logic                                   bank_we,
    output logic [glb_mem_pkg::BANK_ADDR_WIDTH-1:0] bank_addr,
    output logic [glb_mem_pkg::DATA_WIDTH-1:0]      bank_wdata,
    output logic                                   ld_rdata_valid,
    output logic [glb_mem_pkg::DATA_WIDTH-1:0]      ld_rdata
);
    // Set when the load side won last
    logic last_ld;

    assign st_gnt = st_req && (!ld_req || last_ld);
    assign ld_gnt = ld_req && (!st_req || !last_ld);

    assign bank_en    = st_gnt || ld_gnt;
    assign bank_we    = st_gnt;
    assign bank_addr  = st_gnt ? st_addr : ld_addr;
    assign bank_wdata = st_wdata;
    assign ld_rdata   = bank_rdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_ld        <= 1'b0;
            ld_rdata_valid <= 1'b0;
        end else begin
            if (st_gnt)
                last_ld <= 1'b0;
            else if (ld_gnt)
                last_ld <= 1'b1;
            // Bank read latency is one cycle
            ld_rdata_valid <= ld_gnt;
        end
    end

    // A waiting load request stays up until the store side releases the bank
    assert property (@(posedge clk) disable iff (!arst_n)
        ld_req && !ld_gnt |=> ld_req)
        else $error("load request dropped before grant");

endmodule

// ==== glb_bank.sv ====
// Module glb_bank: single-port synchronous SRAM model with registered read
`timescale 1ns/1ps

module glb_bank (
    input  logic                                   clk,
    input  logic                                   bank_en,
    input  logic                                   bank_we,
    input  logic [glb_mem_pkg::BANK_ADDR_WIDTH-1:0] bank_addr,
    input  logic [glb_mem_pkg::DATA_WIDTH-1:0]      bank_wdata,
    output logic [glb_mem_pkg::DATA_WIDTH-1:0]      bank_rdata
);
    import glb_mem_pkg::*;

    logic [DATA_WIDTH-1:0] mem [BANK_DEPTH];

    always_ff @(posedge clk) begin
        if (bank_en) begin
            if (bank_we)
                mem[bank_addr] <= bank_wdata;
            else
                bank_rdata <= mem[bank_addr];
        end
    end

endmodule

// ==== glb_reg_pkg.sv ====
// APB register map of the tile: widths, register addresses, field offsets, control bits
package glb_reg_pkg;

    localparam int APB_ADDR_WIDTH = 6;
    localparam int APB_DATA_WIDTH = 32;

    // Byte addresses, one register per 32-bit word
    localparam int REG_TILE_CTRL   = 'h00;
    localparam int REG_ST_HDR_BASE = 'h04;
    localparam int REG_LD_HDR_BASE = 'h20;
    localparam int REG_HDR_STRIDE  = 'h10;

    // Offsets inside one header
    localparam int OFS_VALIDATE   = 'h0;
    localparam int OFS_START_ADDR = 'h4;
    localparam int OFS_NUM_WORDS  = 'h8;
    localparam int OFS_RANGE      = 'h8;
    localparam int OFS_STRIDE     = 'hC;

    // TILE_CTRL bits
    localparam int CTRL_ST_EN_BIT = 0;
    localparam int CTRL_LD_EN_BIT = 1;

endpackage

// ==== glb_mem_pkg.sv ====
// Bank geometry, data width, queue and FIFO sizes, DMA header structs
package glb_mem_pkg;

    localparam int DATA_WIDTH      = 16;
    localparam int BANK_ADDR_WIDTH = 10;
    localparam int BANK_DEPTH      = 1 << BANK_ADDR_WIDTH;

    // Header slots per direction, kept a power of two so slot pointers wrap
    localparam int QUEUE_DEPTH     = 2;
    localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);

    localparam int NUM_WORDS_WIDTH = 11;
    localparam int STRIDE_WIDTH    = 8;

    // Load return FIFO, also the limit on reads in flight plus queued words
    localparam int LD_FIFO_DEPTH   = 2;
    localparam int LD_PTR_WIDTH    = $clog2(LD_FIFO_DEPTH);
    localparam int LD_CNT_WIDTH    = $clog2(LD_FIFO_DEPTH + 1);

    typedef struct packed {
        logic                       valid;
        logic [BANK_ADDR_WIDTH-1:0] start_addr;
        logic [NUM_WORDS_WIDTH-1:0] num_words;
    } dma_st_header_t;

    // One loop level: range words spaced stride apart
    typedef struct packed {
        logic                       valid;
        logic [BANK_ADDR_WIDTH-1:0] start_addr;
        logic [NUM_WORDS_WIDTH-1:0] range;
        logic [STRIDE_WIDTH-1:0]    stride;
    } dma_ld_header_t;

endpackage
